/* common/bp_isa_pkg.sv */
`default_nettype none

package bp_isa_pkg;

    // width of an instruction address
    localparam int PC_BITS = 32;

    // instructions are word aligned, so the low bits never index anything
    localparam int INSTR_ALIGN_BITS = 2;

    // byte address of one instruction word
    typedef logic [PC_BITS-1:0] pc_t;

    // sequential fetch step
    localparam pc_t INSTR_BYTES = pc_t'(4);

endpackage

`default_nettype wire

/* common/bp_cfg_pkg.sv */
`default_nettype none

package bp_cfg_pkg;

    import bp_isa_pkg::pc_t;

    // 2-bit saturating counter
    // upper bit is the decision: taken for direction tables, gshare for the chooser
    typedef logic [1:0] counter_t;

    localparam counter_t COUNTER_MIN = 2'b00;
    localparam counter_t COUNTER_MAX = 2'b11;

    // weakly not taken / weakly bimodal
    localparam counter_t COUNTER_RESET = 2'b01;

    // one resolved branch from execute
    typedef struct packed {
        pc_t  pc;
        pc_t  target;
        logic taken;
    } resolve_t;

    // fetch request from the fetch stage
    typedef struct packed {
        pc_t  pc;
        logic is_branch;
    } fetch_req_t;

    // credit / occupancy count, covers a queue depth up to 8
    typedef logic [3:0] credit_t;

endpackage

`default_nettype wire

/* hw/btb/btb.sv */
`timescale 1ns/100ps
`default_nettype none

module btb
    import bp_isa_pkg::*;
    import bp_cfg_pkg::*;
#(
    parameter int BTB_INDEX_BITS = 4
) (
    input  logic CLK,
    input  logic arst_n,
    input  pc_t  fetch_pc,
    input  logic wr_en,
    input  pc_t  wr_pc,
    input  pc_t  wr_target,
    output logic hit,
    output pc_t  target
);

    localparam int ENTRIES  = 2 ** BTB_INDEX_BITS;
    localparam int TAG_BITS = PC_BITS - BTB_INDEX_BITS - INSTR_ALIGN_BITS;
    localparam int TAG_LSB  = BTB_INDEX_BITS + INSTR_ALIGN_BITS;

    logic [ENTRIES-1:0]  valid;
    logic [TAG_BITS-1:0] tags [ENTRIES];
    pc_t                 targets [ENTRIES];

    logic [BTB_INDEX_BITS-1:0] fetch_index;
    logic [BTB_INDEX_BITS-1:0] wr_index;
    logic [TAG_BITS-1:0]       fetch_tag;
    logic [TAG_BITS-1:0]       wr_tag;

    // index sits just above the alignment bits, tag is everything above it
    assign fetch_index = fetch_pc[TAG_LSB-1:INSTR_ALIGN_BITS];
    assign fetch_tag   = fetch_pc[PC_BITS-1:TAG_LSB];
    assign wr_index    = wr_pc[TAG_LSB-1:INSTR_ALIGN_BITS];
    assign wr_tag      = wr_pc[PC_BITS-1:TAG_LSB];

    // combinational lookup for fetch
    assign hit    = valid[fetch_index] && (tags[fetch_index] == fetch_tag);
    assign target = targets[fetch_index];

    // valid bits start clear
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_index] <= 1'b1;
        end
    end

    // tag and target storage, a write replaces the whole entry
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            tags[wr_index]    <= wr_tag;
            targets[wr_index] <= wr_target;
        end
    end

endmodule

`default_nettype wire

/* hw/counter_table/sat_counter_table.sv */
`timescale 1ns/100ps
`default_nettype none

module sat_counter_table
    import bp_isa_pkg::*;
    import bp_cfg_pkg::*;
#(
    parameter int INDEX_BITS = 6
) (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic [INDEX_BITS-1:0] rd_index,
    input  logic [INDEX_BITS-1:0] res_index,
    input  logic                  upd_en,
    input  logic                  upd_up,
    output counter_t              rd_counter,
    output counter_t              res_counter
);

    localparam int ENTRIES = 2 ** INDEX_BITS;

    counter_t counters [ENTRIES];
    counter_t next_counter;

    // fetch read and resolution read
    assign rd_counter  = counters[rd_index];
    assign res_counter = counters[res_index];

    // step toward the outcome, stick at either end
    always_comb begin
        next_counter = res_counter;
        if (upd_up && res_counter != COUNTER_MAX) begin
            next_counter = res_counter + counter_t'(1);
        end else if (!upd_up && res_counter != COUNTER_MIN) begin
            next_counter = res_counter - counter_t'(1);
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= COUNTER_RESET;
            end
        end else if (upd_en) begin
            counters[res_index] <= next_counter;
        end
    end

endmodule

`default_nettype wire

/* hw/ghr.sv */
`timescale 1ns/100ps
`default_nettype none

module ghr
    import bp_isa_pkg::*;
    import bp_cfg_pkg::*;
#(
    parameter int GHR_BITS = 6
) (
    input  logic                CLK,
    input  logic                arst_n,
    input  logic                shift_en,
    input  logic                taken_in,
    output logic [GHR_BITS-1:0] history
);

    // newest outcome enters at bit 0, oldest falls off the top
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            history <= '0;
        end else if (shift_en) begin
            history <= {history[GHR_BITS-2:0], taken_in};
        end
    end

endmodule

`default_nettype wire

/* hw/update_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module update_queue
    import bp_isa_pkg::*;
    import bp_cfg_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic     CLK,
    input  logic     arst_n,
    input  logic     push,
    input  resolve_t push_data,
    output logic     pop_valid,
    output resolve_t pop_data
);

    localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(QUEUE_DEPTH - 1);

    resolve_t            entries [QUEUE_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    credit_t             count;

    // head leaves in the same cycle it is shown
    assign pop_valid = (count != '0);
    assign pop_data  = entries[rd_ptr];

    // the sender's credits keep a push from ever landing on a full queue
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + PTR_BITS'(1);
            end
            if (pop_valid) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + PTR_BITS'(1);
            end
            case ({push, pop_valid})
                2'b10:   count <= count + credit_t'(1);
                2'b01:   count <= count - credit_t'(1);
                default: count <= count;
            endcase
        end
    end

    // payload storage
    always_ff @(posedge CLK) begin
        if (push) begin
            entries[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

/* hw/tournament/fetch_tbp.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_tbp
    import bp_isa_pkg::*;
    import bp_cfg_pkg::*;
#(
    parameter int TABLE_INDEX_BITS = 6,
    parameter int BTB_INDEX_BITS   = 4,
    parameter int GHR_BITS         = 6
) (
    input  logic       CLK,
    input  logic       arst_n,
    input  fetch_req_t fetch,
    input  logic       upd_valid,
    input  resolve_t   upd,
    output pc_t        next_pc
);

    localparam int IDX_MSB = TABLE_INDEX_BITS + INSTR_ALIGN_BITS - 1;

    logic [GHR_BITS-1:0]         history;
    logic [TABLE_INDEX_BITS-1:0] history_ext;
    logic [TABLE_INDEX_BITS-1:0] fetch_index;
    logic [TABLE_INDEX_BITS-1:0] res_index;
    logic [TABLE_INDEX_BITS-1:0] gshare_fetch_index;
    logic [TABLE_INDEX_BITS-1:0] gshare_res_index;

    counter_t gshare_rd;
    counter_t gshare_res;
    counter_t bimodal_rd;
    counter_t bimodal_res;
    counter_t chooser_rd;

    logic gshare_correct;
    logic bimodal_correct;
    logic chooser_en;
    logic taken;
    logic btb_hit;
    pc_t  btb_target;

    btb #(
        .BTB_INDEX_BITS(BTB_INDEX_BITS)
    ) btb_inst (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .fetch_pc (fetch.pc),
        .wr_en    (upd_valid && upd.taken),
        .wr_pc    (upd.pc),
        .wr_target(upd.target),
        .hit      (btb_hit),
        .target   (btb_target)
    );

    ghr #(
        .GHR_BITS(GHR_BITS)
    ) ghr_inst (
        .CLK     (CLK),
        .arst_n  (arst_n),
        .shift_en(upd_valid),
        .taken_in(upd.taken),
        .history (history)
    );

    // history is zero extended into the table index
    assign history_ext        = TABLE_INDEX_BITS'(history);
    assign fetch_index        = fetch.pc[IDX_MSB:INSTR_ALIGN_BITS];
    assign res_index          = upd.pc[IDX_MSB:INSTR_ALIGN_BITS];
    assign gshare_fetch_index = fetch_index ^ history_ext;
    assign gshare_res_index   = res_index ^ history_ext;

    sat_counter_table #(
        .INDEX_BITS(TABLE_INDEX_BITS)
    ) gshare_table (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .rd_index   (gshare_fetch_index),
        .res_index  (gshare_res_index),
        .upd_en     (upd_valid),
        .upd_up     (upd.taken),
        .rd_counter (gshare_rd),
        .res_counter(gshare_res)
    );

    sat_counter_table #(
        .INDEX_BITS(TABLE_INDEX_BITS)
    ) bimodal_table (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .rd_index   (fetch_index),
        .res_index  (res_index),
        .upd_en     (upd_valid),
        .upd_up     (upd.taken),
        .rd_counter (bimodal_rd),
        .res_counter(bimodal_res)
    );

    // chooser only moves when exactly one predictor got it right
    assign gshare_correct  = (gshare_res[1] == upd.taken);
    assign bimodal_correct = (bimodal_res[1] == upd.taken);
    assign chooser_en      = upd_valid && (gshare_correct != bimodal_correct);

    sat_counter_table #(
        .INDEX_BITS(TABLE_INDEX_BITS)
    ) chooser_table (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .rd_index   (fetch_index),
        .res_index  (res_index),
        .upd_en     (chooser_en),
        .upd_up     (gshare_correct),
        .rd_counter (chooser_rd),
        .res_counter()
    );

    // chooser upper bit selects gshare
    assign taken = chooser_rd[1] ? gshare_rd[1] : bimodal_rd[1];

    always_comb begin
        if (fetch.is_branch && taken && btb_hit) begin
            next_pc = btb_target;
        end else begin
            next_pc = fetch.pc + INSTR_BYTES;
        end
    end

endmodule

`default_nettype wire

/* hw/bp_top.sv */
`timescale 1ns/100ps
`default_nettype none

module bp_top
    import bp_isa_pkg::*;
    import bp_cfg_pkg::*;
#(
    parameter int TABLE_INDEX_BITS = 6,
    parameter int BTB_INDEX_BITS   = 4,
    parameter int GHR_BITS         = 6,
    parameter int QUEUE_DEPTH      = 4
) (
    input  logic       CLK,
    input  logic       arst_n,
    input  fetch_req_t fetch,
    input  logic       resolve_valid,
    input  resolve_t   resolve,
    output pc_t        next_pc,
    output logic       credit_return
);

    logic     upd_valid;
    resolve_t upd;

    update_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) update_queue_inst (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .push     (resolve_valid),
        .push_data(resolve),
        .pop_valid(upd_valid),
        .pop_data (upd)
    );

    fetch_tbp #(
        .TABLE_INDEX_BITS(TABLE_INDEX_BITS),
        .BTB_INDEX_BITS  (BTB_INDEX_BITS),
        .GHR_BITS        (GHR_BITS)
    ) fetch_tbp_inst (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .fetch    (fetch),
        .upd_valid(upd_valid),
        .upd      (upd),
        .next_pc  (next_pc)
    );

    // one credit back per popped entry
    assign credit_return = upd_valid;

endmodule

`default_nettype wire

/* verification/tb_bp_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_bp_top
    import bp_isa_pkg::*;
    import bp_cfg_pkg::*;
();

    localparam int TABLE_INDEX_BITS = 6;
    localparam int BTB_INDEX_BITS   = 4;
    localparam int GHR_BITS         = 6;
    localparam int QUEUE_DEPTH      = 4;
    localparam int TABLE_ENTRIES    = 2 ** TABLE_INDEX_BITS;
    localparam int BTB_ENTRIES      = 2 ** BTB_INDEX_BITS;
    localparam int WAIT_LIMIT       = 100;

    // branches used by the directed tests, a and b alias in the btb
    localparam pc_t PC_A     = 32'h0000_0040;
    localparam pc_t TARGET_A = 32'h0000_0800;
    localparam pc_t PC_B     = 32'h0000_0080;
    localparam pc_t TARGET_B = 32'h0000_0900;
    localparam pc_t PC_C     = 32'h0000_0124;
    localparam pc_t TARGET_C = 32'h0000_0c00;

    logic       clk;
    logic       arst_n;
    fetch_req_t fetch;
    logic       resolve_valid;
    resolve_t   resolve;
    pc_t        next_pc;
    logic       credit_return;

    // reference model of every table
    counter_t            m_gshare  [TABLE_ENTRIES];
    counter_t            m_bimodal [TABLE_ENTRIES];
    counter_t            m_chooser [TABLE_ENTRIES];
    logic                m_valid   [BTB_ENTRIES];
    pc_t                 m_tag     [BTB_ENTRIES];
    pc_t                 m_target  [BTB_ENTRIES];
    logic [GHR_BITS-1:0] m_ghr;

    resolve_t pending [$];
    int       credits;
    int       returned_total;
    int       n_pass;
    int       n_fail;
    logic     timed_out;
    int       seed;
    pc_t      stream_pcs [8];

    bp_top #(
        .TABLE_INDEX_BITS(TABLE_INDEX_BITS),
        .BTB_INDEX_BITS  (BTB_INDEX_BITS),
        .GHR_BITS        (GHR_BITS),
        .QUEUE_DEPTH     (QUEUE_DEPTH)
    ) bp_top_inst (
        .CLK          (clk),
        .arst_n       (arst_n),
        .fetch        (fetch),
        .resolve_valid(resolve_valid),
        .resolve      (resolve),
        .next_pc      (next_pc),
        .credit_return(credit_return)
    );

    always #2 clk = ~clk;

    function automatic counter_t sat_step(input counter_t c, input logic up);
        if (up) begin
            return (c == 2'b11) ? c : c + 2'b01;
        end
        return (c == 2'b00) ? c : c - 2'b01;
    endfunction

    function automatic int table_index(input pc_t pc);
        return int'((pc >> 2) % TABLE_ENTRIES);
    endfunction

    function automatic int btb_index(input pc_t pc);
        return int'((pc >> 2) % BTB_ENTRIES);
    endfunction

    function automatic resolve_t make_resolve(input pc_t pc, input pc_t target, input logic taken);
        resolve_t r;
        r.pc     = pc;
        r.target = target;
        r.taken  = taken;
        return r;
    endfunction

    function automatic void model_reset();
        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            m_gshare[i]  = 2'b01;
            m_bimodal[i] = 2'b01;
            m_chooser[i] = 2'b01;
        end
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_target[i] = '0;
        end
        m_ghr = '0;
    endfunction

    function automatic void model_apply(input resolve_t r);
        int   ti;
        int   gi;
        int   bi;
        logic g_ok;
        logic b_ok;
        ti   = table_index(r.pc);
        gi   = ti ^ int'(m_ghr);
        bi   = btb_index(r.pc);
        g_ok = (m_gshare[gi][1] == r.taken);
        b_ok = (m_bimodal[ti][1] == r.taken);
        if (g_ok && !b_ok) begin
            m_chooser[ti] = sat_step(m_chooser[ti], 1'b1);
        end else if (b_ok && !g_ok) begin
            m_chooser[ti] = sat_step(m_chooser[ti], 1'b0);
        end
        m_gshare[gi]  = sat_step(m_gshare[gi], r.taken);
        m_bimodal[ti] = sat_step(m_bimodal[ti], r.taken);
        if (r.taken) begin
            m_valid[bi]  = 1'b1;
            m_tag[bi]    = r.pc >> (BTB_INDEX_BITS + 2);
            m_target[bi] = r.target;
        end
        m_ghr = {m_ghr[GHR_BITS-2:0], r.taken};
    endfunction

    function automatic pc_t model_next_pc(input pc_t pc, input logic is_branch);
        int   ti;
        int   bi;
        logic predict_taken;
        logic hit;
        ti = table_index(pc);
        bi = btb_index(pc);
        if (m_chooser[ti][1]) begin
            predict_taken = m_gshare[ti ^ int'(m_ghr)][1];
        end else begin
            predict_taken = m_bimodal[ti][1];
        end
        hit = m_valid[bi] && (m_tag[bi] == (pc >> (BTB_INDEX_BITS + 2)));
        if (is_branch && predict_taken && hit) begin
            return m_target[bi];
        end
        return pc + INSTR_BYTES;
    endfunction

    // a returned credit marks the pop, tables change at the next edge
    always @(negedge clk) begin
        if (arst_n && credit_return) begin
            if (pending.size() == 0) begin
                n_fail++;
                $display("credit returned while no update was outstanding");
            end else begin
                model_apply(pending.pop_front());
            end
            credits++;
            returned_total++;
        end
    end

    task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
        if (actual === expected) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_credit(input string name, input credit_t expected, input credit_t actual);
        if (actual === expected) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("Fail %s: expected %0d credits, actual %0d", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (n_fail == fails_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d check(s) failed", name, n_fail - fails_before);
        end
    endtask

    task automatic report_timeout(input string what);
        if (!timed_out) begin
            $display("Timeout: %s", what);
            n_fail++;
        end
        timed_out = 1'b1;
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            resolve_valid <= 1'b0;
        end
    endtask

    // only sends while the sender holds a credit
    task automatic send_update(input resolve_t r);
        int waited;
        waited = 0;
        while (credits == 0 && !timed_out) begin
            @(posedge clk);
            resolve_valid <= 1'b0;
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("no credit came back to the sender");
            end
        end
        if (!timed_out) begin
            @(posedge clk);
            resolve_valid <= 1'b1;
            resolve       <= r;
            credits--;
            pending.push_back(r);
        end
    endtask

    task automatic drain_updates();
        int waited;
        waited = 0;
        drive_idle(1);
        while (pending.size() != 0 && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("sent updates were never popped from the queue");
            end
        end
    endtask

    task automatic fetch_and_check(input string name, input pc_t pc, input logic is_branch,
                                   input pc_t expected);
        fetch_req_t req;
        req.pc        = pc;
        req.is_branch = is_branch;
        if (!timed_out) begin
            @(posedge clk);
            fetch <= req;
            @(negedge clk);
            check_pc(name, expected, next_pc);
        end
    endtask

    task automatic test_reset_state();
        int  fails_before;
        int  returned_before;
        pc_t pc;
        fails_before = n_fail;
        for (int i = 0; i < 6; i++) begin
            pc = pc_t'(32'h0000_0200 + i * 32'h34);
            fetch_and_check("reset_state", pc, 1'b1, pc + INSTR_BYTES);
            fetch_and_check("reset_state", pc, 1'b0, pc + INSTR_BYTES);
        end
        returned_before = returned_total;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            send_update(make_resolve(pc_t'(32'h0000_02c0 + i * 4), 32'h0000_4000, 1'b0));
        end
        drain_updates();
        check_credit("reset_state", credit_t'(QUEUE_DEPTH),
                     credit_t'(returned_total - returned_before));
        report_test("reset_state", fails_before);
    endtask

    task automatic test_bimodal_learn();
        int fails_before;
        int returned_before;
        fails_before    = n_fail;
        returned_before = returned_total;
        send_update(make_resolve(PC_A, TARGET_A, 1'b1));
        drain_updates();
        check_credit("bimodal_learn", credit_t'(1), credit_t'(returned_total - returned_before));
        fetch_and_check("bimodal_learn", PC_A, 1'b1, TARGET_A);
        fetch_and_check("bimodal_learn", PC_A, 1'b0, PC_A + INSTR_BYTES);
        report_test("bimodal_learn", fails_before);
    endtask

    // b trains its counters, then a takes the shared btb entry back
    task automatic test_btb_tag_miss();
        int fails_before;
        fails_before = n_fail;
        send_update(make_resolve(PC_B, TARGET_B, 1'b1));
        send_update(make_resolve(PC_B, TARGET_B, 1'b1));
        send_update(make_resolve(PC_A, TARGET_A, 1'b1));
        drain_updates();
        fetch_and_check("btb_tag_miss", PC_A, 1'b1, TARGET_A);
        fetch_and_check("btb_tag_miss", PC_B, 1'b1, PC_B + INSTR_BYTES);
        report_test("btb_tag_miss", fails_before);
    endtask

    task automatic test_chooser_switch();
        int fails_before;
        fails_before = n_fail;
        // taken, not taken, ... ending on not taken
        for (int i = 0; i < 20; i++) begin
            send_update(make_resolve(PC_C, TARGET_C, (i % 2) == 0));
            drain_updates();
            fetch_and_check("chooser_switch", PC_C, 1'b1, model_next_pc(PC_C, 1'b1));
        end
        // bimodal now says not taken, gshare expects taken after a not taken
        fetch_and_check("chooser_switch", PC_C, 1'b1, TARGET_C);
        report_test("chooser_switch", fails_before);
    endtask

    task automatic test_burst_backpressure();
        int   fails_before;
        int   returned_before;
        pc_t  pc;
        pc_t  target;
        logic taken;
        fails_before    = n_fail;
        returned_before = returned_total;
        for (int i = 0; i < 3 * QUEUE_DEPTH; i++) begin
            pc     = stream_pcs[{$random(seed)} % 8];
            target = pc_t'($random(seed)) & ~pc_t'(3);
            taken  = ($random(seed) % 2) != 0;
            send_update(make_resolve(pc, target, taken));
        end
        drain_updates();
        check_credit("burst_backpressure", credit_t'(3 * QUEUE_DEPTH),
                     credit_t'(returned_total - returned_before));
        check_credit("burst_backpressure", credit_t'(QUEUE_DEPTH), credit_t'(credits));
        report_test("burst_backpressure", fails_before);
    endtask

    task automatic test_random_stream();
        int   fails_before;
        int   idle;
        pc_t  pc;
        pc_t  target;
        logic taken;
        fails_before = n_fail;
        for (int n = 0; n < 200; n++) begin
            pc     = stream_pcs[{$random(seed)} % 8];
            target = pc_t'($random(seed)) & ~pc_t'(3);
            taken  = ($random(seed) % 2) != 0;
            idle   = {$random(seed)} % 4;
            send_update(make_resolve(pc, target, taken));
            drive_idle(idle);
            drain_updates();
            for (int k = 0; k < 8; k++) begin
                fetch_and_check("random_stream", stream_pcs[k], 1'b1,
                                model_next_pc(stream_pcs[k], 1'b1));
            end
        end
        report_test("random_stream", fails_before);
    endtask

    initial begin
        clk            = 1'b0;
        arst_n         = 1'b0;
        fetch          = '0;
        resolve_valid  = 1'b0;
        resolve        = '0;
        credits        = QUEUE_DEPTH;
        returned_total = 0;
        n_pass         = 0;
        n_fail         = 0;
        timed_out      = 1'b0;
        seed           = 76232;
        // 3000/3040 and 3004/3044 share btb entries
        stream_pcs = '{32'h0000_3000, 32'h0000_3004, 32'h0000_3040, 32'h0000_3044,
                       32'h0000_3108, 32'h0000_310c, 32'h0000_3250, 32'h0000_3af0};
        model_reset();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        test_reset_state();
        test_bimodal_learn();
        test_btb_tag_miss();
        test_chooser_switch();
        test_burst_backpressure();
        test_random_stream();
        drive_idle(2);

        $display("checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
common/bp_isa_pkg.sv
common/bp_cfg_pkg.sv
hw/btb/btb.sv
hw/counter_table/sat_counter_table.sv
hw/ghr.sv
hw/update_queue.sv
hw/tournament/fetch_tbp.sv
hw/bp_top.sv
verification/tb_bp_top.sv

/* Bender.yml */
package:
  name: bp_top

sources:
  # packages first, then the design bottom up
  - common/bp_isa_pkg.sv
  - common/bp_cfg_pkg.sv
  - hw/btb/btb.sv
  - hw/counter_table/sat_counter_table.sv
  - hw/ghr.sv
  - hw/update_queue.sv
  - hw/tournament/fetch_tbp.sv
  - hw/bp_top.sv
  - target: test
    files:
      - verification/tb_bp_top.sv
